//--- design/fifo_cfg.svh
`ifndef FIFO_CFG_SVH
`define FIFO_CFG_SVH

// --------------------------------------------------
// FIFO build configuration
// --------------------------------------------------

// Address bits, depth is 2**FIFO_ADDR_WIDTH
`define FIFO_ADDR_WIDTH 4

// Bits per stored entry
`define FIFO_DATA_WIDTH 8

// Almost-full once occupancy reaches depth minus this
`define FIFO_ALMOST_WR_MARGIN 2

// Almost-empty while occupancy is at or below this
`define FIFO_ALMOST_RD_MARGIN 2

// Read port mode, 0 = mux, 1 = flop
`define FIFO_REGISTERED 1

`endif

//--- design/fifo_pkg.sv
`include "fifo_cfg.svh"

package fifo_pkg;

        // --------------------------------------------------
        // Pointer and data types
        // --------------------------------------------------

        // Address bits plus one wrap bit
        typedef logic [`FIFO_ADDR_WIDTH:0] fifo_ptr_t;

        // One stored entry
        typedef logic [`FIFO_DATA_WIDTH-1:0] fifo_data_t;

        // --------------------------------------------------
        // Status flags, one struct per clock domain
        // --------------------------------------------------

        // Write side, in wr_clk
        typedef struct packed {
                logic full;
                logic almost_full;
        } fifo_wr_flags_t;

        // Read side, in rd_clk
        typedef struct packed {
                logic      empty;
                logic      almost_empty;
                fifo_ptr_t count;
        } fifo_rd_flags_t;

endpackage

//--- design/fifo_ptr_domain.sv
`timescale 1ns/1ps

// One side of the FIFO
// Owns the local pointer, exports it as Gray code and
// brings the other side's Gray pointer into this clock
module fifo_ptr_domain import fifo_pkg::*; (
        input  logic      clk,
        input  logic      rst_n,
        // Advance request from the user side
        input  logic      inc,
        // Full or empty flag of this side
        input  logic      blocked,
        // Accepted advance this cycle
        output logic      step,
        output fifo_ptr_t ptr_bin,
        output fifo_ptr_t ptr_bin_next,
        output fifo_ptr_t ptr_gray,
        // Other side's Gray pointer, still in its own clock
        input  fifo_ptr_t far_ptr_gray,
        // Same pointer, synchronized and back in binary
        output fifo_ptr_t far_ptr_bin
);

        localparam int PW = $bits(fifo_ptr_t);

        // Two synchronizer stages for the far pointer
        fifo_ptr_t far_sync_q1;
        fifo_ptr_t far_sync_q2;

        // --------------------------------------------------
        // Local pointer
        // --------------------------------------------------

        // Qualified once here, reused by storage and control
        assign step = inc & ~blocked;

        // Next-state pointer, fed to the flag logic
        assign ptr_bin_next = ptr_bin + fifo_ptr_t'(step);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        ptr_bin  <= '0;
                        ptr_gray <= '0;
                end else begin
                        ptr_bin  <= ptr_bin_next;
                        // Gray copy straight from a flop, no glitches on the crossing
                        ptr_gray <= ptr_bin_next ^ (ptr_bin_next >> 1);
                end
        end

        // --------------------------------------------------
        // Far pointer synchronizer
        // --------------------------------------------------

        // First stage may go metastable, second settles it
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        far_sync_q1 <= '0;
                        far_sync_q2 <= '0;
                end else begin
                        far_sync_q1 <= far_ptr_gray;
                        far_sync_q2 <= far_sync_q1;
                end
        end

        // Gray to binary
        // Each bit is the XOR of itself and every bit above it
        always_comb begin
                for (int i = 0; i < PW; i++) begin
                        far_ptr_bin[i] = ^(far_sync_q2 >> i);
                end
        end

        // --------------------------------------------------
        // Checks
        // --------------------------------------------------

        // Full or empty must freeze the pointer
        a_blocked_hold: assert property (
                @(posedge clk) disable iff (!rst_n)
                blocked |=> $stable(ptr_bin)
        );

endmodule

//--- design/fifo_ram.sv
`timescale 1ns/1ps

`include "fifo_cfg.svh"

// Dual-clock storage
// Write port in wr_clk, read port in rd_clk
module fifo_ram import fifo_pkg::*; #(
        // 0 reads straight through a mux, 1 adds an output flop
        parameter int REGISTERED = `FIFO_REGISTERED
) (
        input  logic                        wr_clk,
        // Already qualified by not-full
        input  logic                        wr_en,
        input  logic [`FIFO_ADDR_WIDTH-1:0] wr_addr,
        input  fifo_data_t                  wr_data,
        input  logic                        rd_clk,
        input  logic                        rd_rst_n,
        input  logic [`FIFO_ADDR_WIDTH-1:0] rd_addr,
        output fifo_data_t                  rd_data
);

        localparam int DEPTH = 1 << `FIFO_ADDR_WIDTH;

        // Storage array
        fifo_data_t mem [DEPTH];

        // --------------------------------------------------
        // Write port
        // --------------------------------------------------

        always_ff @(posedge wr_clk) begin
                if (wr_en) begin
                        mem[wr_addr] <= wr_data;
                end
        end

        // --------------------------------------------------
        // Read port
        // --------------------------------------------------

        if (REGISTERED != 0) begin : g_flop
                // Address is the next read slot
                // New head shows right after the pop edge
                always_ff @(posedge rd_clk or negedge rd_rst_n) begin
                        if (!rd_rst_n) begin
                                rd_data <= '0;
                        end else begin
                                rd_data <= mem[rd_addr];
                        end
                end
        end else begin : g_mux
                // Head entry through the read mux
                assign rd_data = mem[rd_addr];
        end

endmodule

//--- design/fifo_control.sv
`timescale 1ns/1ps

`include "fifo_cfg.svh"

// Status flags for the dual-clock FIFO
// Inputs are binary pointers already brought into the matching clock
// Local pointers are next-state, so flags describe the FIFO after the edge
module fifo_control import fifo_pkg::*; #(
        parameter int ADDR_WIDTH       = `FIFO_ADDR_WIDTH,
        parameter int DEPTH            = 1 << `FIFO_ADDR_WIDTH,
        parameter int ALMOST_WR_MARGIN = `FIFO_ALMOST_WR_MARGIN,
        parameter int ALMOST_RD_MARGIN = `FIFO_ALMOST_RD_MARGIN,
        // 1 delays empty by one read cycle to match the output flop
        parameter int REGISTERED       = `FIFO_REGISTERED
) (
        input  logic           wr_clk,
        input  logic           wr_rst_n,
        input  logic           rd_clk,
        input  logic           rd_rst_n,
        // Write domain view
        input  fifo_ptr_t      wr_ptr_bin,
        input  fifo_ptr_t      wdom_rd_ptr_bin,
        // Read domain view
        input  fifo_ptr_t      rd_ptr_bin,
        input  fifo_ptr_t      rdom_wr_ptr_bin,
        output fifo_wr_flags_t wr_flags,
        output fifo_rd_flags_t rd_flags
);

        localparam int AW = ADDR_WIDTH;
        // Thresholds in count width
        localparam logic [AW:0] FULL_LEVEL   = (AW+1)'(DEPTH);
        localparam logic [AW:0] AFULL_LEVEL  = (AW+1)'(DEPTH - ALMOST_WR_MARGIN);
        localparam logic [AW:0] AEMPTY_LEVEL = (AW+1)'(ALMOST_RD_MARGIN);

        logic        full_d;
        logic        almost_full_d;
        logic        empty_d;
        logic        almost_empty_d;
        logic [AW:0] wr_used;
        logic [AW:0] rd_used;
        fifo_ptr_t   wr_ptr_for_empty;

        // Occupancy from a write and a read pointer
        // Kept one bit wider than the address so DEPTH itself fits
        function automatic logic [AW:0] used_entries(input logic [AW:0] wptr,
                                                     input logic [AW:0] rptr);
                logic [AW:0] wlo;
                logic [AW:0] rlo;
                wlo = {1'b0, wptr[AW-1:0]};
                rlo = {1'b0, rptr[AW-1:0]};
                // Wrap bits differ, writer is one lap ahead
                if (wptr[AW] != rptr[AW]) begin
                        used_entries = FULL_LEVEL - rlo + wlo;
                end else begin
                        used_entries = wlo - rlo;
                end
        endfunction

        // --------------------------------------------------
        // Write domain
        // --------------------------------------------------

        // Full when a whole lap apart on the same slot
        assign full_d = (wr_ptr_bin[AW] != wdom_rd_ptr_bin[AW]) &&
                        (wr_ptr_bin[AW-1:0] == wdom_rd_ptr_bin[AW-1:0]);

        assign wr_used       = used_entries(wr_ptr_bin, wdom_rd_ptr_bin);
        assign almost_full_d = wr_used >= AFULL_LEVEL;

        always_ff @(posedge wr_clk or negedge wr_rst_n) begin
                if (!wr_rst_n) begin
                        wr_flags <= '0;
                end else begin
                        wr_flags.full        <= full_d;
                        wr_flags.almost_full <= almost_full_d;
                end
        end

        // --------------------------------------------------
        // Read domain
        // --------------------------------------------------

        if (REGISTERED != 0) begin : g_flop_empty
                // One more rd_clk so the output flop has loaded the word
                fifo_ptr_t wr_ptr_dly;
                always_ff @(posedge rd_clk or negedge rd_rst_n) begin
                        if (!rd_rst_n) begin
                                wr_ptr_dly <= '0;
                        end else begin
                                wr_ptr_dly <= rdom_wr_ptr_bin;
                        end
                end
                assign wr_ptr_for_empty = wr_ptr_dly;
        end else begin : g_mux_empty
                assign wr_ptr_for_empty = rdom_wr_ptr_bin;
        end

        // Empty when both pointers match, wrap bit included
        assign empty_d = (rd_ptr_bin == wr_ptr_for_empty);

        // Count and almost-empty use the undelayed pointer
        assign rd_used        = used_entries(rdom_wr_ptr_bin, rd_ptr_bin);
        assign almost_empty_d = rd_used <= AEMPTY_LEVEL;

        always_ff @(posedge rd_clk or negedge rd_rst_n) begin
                if (!rd_rst_n) begin
                        rd_flags.empty        <= 1'b1;
                        rd_flags.almost_empty <= 1'b0;
                        rd_flags.count        <= '0;
                end else begin
                        rd_flags.empty        <= empty_d;
                        rd_flags.almost_empty <= almost_empty_d;
                        rd_flags.count        <= rd_used;
                end
        end

        // --------------------------------------------------
        // Checks
        // --------------------------------------------------

        // Pointer math only works for power-of-two depths
        a_depth_pow2: assert property (
                @(posedge wr_clk) DEPTH == (1 << ADDR_WIDTH)
        );

        a_full_afull: assert property (
                @(posedge wr_clk) disable iff (!wr_rst_n)
                wr_flags.full |-> wr_flags.almost_full
        );

        // Synchronized write pointer can never run a lap past the reader
        a_count_max: assert property (
                @(posedge rd_clk) disable iff (!rd_rst_n)
                rd_flags.count <= FULL_LEVEL
        );

endmodule

//--- design/fifo_async.sv
`timescale 1ns/1ps

`include "fifo_cfg.svh"

// Dual-clock FIFO, write domain to read domain
// First-word-fall-through read side
module fifo_async import fifo_pkg::*; (
        // Write side
        input  logic           wr_clk,
        input  logic           wr_rst_n,
        input  logic           wr_en,
        input  fifo_data_t     wr_data,
        // Read side
        input  logic           rd_clk,
        input  logic           rd_rst_n,
        input  logic           rd_en,
        // Head entry whenever rd_flags.empty is low
        output fifo_data_t     rd_data,
        output fifo_wr_flags_t wr_flags,
        output fifo_rd_flags_t rd_flags
);

        // --------------------------------------------------
        // Wires
        // --------------------------------------------------

        // Write domain pointers
        logic      wr_step;
        fifo_ptr_t wr_ptr_bin;
        fifo_ptr_t wr_ptr_next;
        fifo_ptr_t wr_ptr_gray;
        fifo_ptr_t wdom_rd_ptr;

        // Read domain pointers
        fifo_ptr_t rd_ptr_bin;
        fifo_ptr_t rd_ptr_next;
        fifo_ptr_t rd_ptr_gray;
        fifo_ptr_t rdom_wr_ptr;

        // Flop mode reads ahead at the next slot
        // Mux mode reads the current head
        logic [`FIFO_ADDR_WIDTH-1:0] rd_addr;

        assign rd_addr = (`FIFO_REGISTERED != 0) ? rd_ptr_next[`FIFO_ADDR_WIDTH-1:0]
                                                 : rd_ptr_bin[`FIFO_ADDR_WIDTH-1:0];

        // --------------------------------------------------
        // Write pointer domain
        // --------------------------------------------------

        fifo_ptr_domain u_wr_ptr (
                .clk          (wr_clk),
                .rst_n        (wr_rst_n),
                .inc          (wr_en),
                .blocked      (wr_flags.full),
                .step         (wr_step),
                .ptr_bin      (wr_ptr_bin),
                .ptr_bin_next (wr_ptr_next),
                .ptr_gray     (wr_ptr_gray),
                .far_ptr_gray (rd_ptr_gray),
                .far_ptr_bin  (wdom_rd_ptr)
        );

        // --------------------------------------------------
        // Read pointer domain
        // --------------------------------------------------

        // Pop strobe is not needed outside this instance
        fifo_ptr_domain u_rd_ptr (
                .clk          (rd_clk),
                .rst_n        (rd_rst_n),
                .inc          (rd_en),
                .blocked      (rd_flags.empty),
                .step         (),
                .ptr_bin      (rd_ptr_bin),
                .ptr_bin_next (rd_ptr_next),
                .ptr_gray     (rd_ptr_gray),
                .far_ptr_gray (wr_ptr_gray),
                .far_ptr_bin  (rdom_wr_ptr)
        );

        // --------------------------------------------------
        // Storage
        // --------------------------------------------------

        fifo_ram #(
                .REGISTERED (`FIFO_REGISTERED)
        ) u_ram (
                .wr_clk   (wr_clk),
                .wr_en    (wr_step),
                .wr_addr  (wr_ptr_bin[`FIFO_ADDR_WIDTH-1:0]),
                .wr_data  (wr_data),
                .rd_clk   (rd_clk),
                .rd_rst_n (rd_rst_n),
                .rd_addr  (rd_addr),
                .rd_data  (rd_data)
        );

        // --------------------------------------------------
        // Flags
        // --------------------------------------------------

        // Local pointers go in as next-state values
        fifo_control #(
                .ADDR_WIDTH       (`FIFO_ADDR_WIDTH),
                .DEPTH            (1 << `FIFO_ADDR_WIDTH),
                .ALMOST_WR_MARGIN (`FIFO_ALMOST_WR_MARGIN),
                .ALMOST_RD_MARGIN (`FIFO_ALMOST_RD_MARGIN),
                .REGISTERED       (`FIFO_REGISTERED)
        ) u_control (
                .wr_clk          (wr_clk),
                .wr_rst_n        (wr_rst_n),
                .rd_clk          (rd_clk),
                .rd_rst_n        (rd_rst_n),
                .wr_ptr_bin      (wr_ptr_next),
                .wdom_rd_ptr_bin (wdom_rd_ptr),
                .rd_ptr_bin      (rd_ptr_next),
                .rdom_wr_ptr_bin (rdom_wr_ptr),
                .wr_flags        (wr_flags),
                .rd_flags        (rd_flags)
        );

endmodule

//--- bench/fifo_tb_util.svh
`ifndef FIFO_TB_UTIL_SVH
`define FIFO_TB_UTIL_SVH

// --------------------------------------------------
// Random source
// --------------------------------------------------

// Galois LFSR state, one step per bit taken
logic [31:0] lfsr_state = 32'h4ce80cbe;

function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
                if (lfsr_state[0]) begin
                        lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
                end else begin
                        lfsr_state = lfsr_state >> 1;
                end
                v = {v[30:0], lfsr_state[0]};
        end
        return v;
endfunction

// --------------------------------------------------
// Reference queue and flags
// --------------------------------------------------

// Words accepted by the DUT and not yet popped
fifo_data_t model_q[$];

localparam int TB_DEPTH = 1 << `FIFO_ADDR_WIDTH;

// Expected write side flags for a settled occupancy
function automatic fifo_wr_flags_t expect_wr_flags(input int n);
        fifo_wr_flags_t f;
        f.full        = (n >= TB_DEPTH);
        f.almost_full = (n >= TB_DEPTH - `FIFO_ALMOST_WR_MARGIN);
        return f;
endfunction

// Expected read side flags for a settled occupancy
function automatic fifo_rd_flags_t expect_rd_flags(input int n);
        fifo_rd_flags_t f;
        f.empty        = (n == 0);
        f.almost_empty = (n <= `FIFO_ALMOST_RD_MARGIN);
        f.count        = fifo_ptr_t'(n);
        return f;
endfunction

// --------------------------------------------------
// Reporting
// --------------------------------------------------

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
                $display("ERR %s expected 0x%0h got 0x%0h", name, expected, actual);
                $display("SIMULATION FAILED");
                $fatal(1);
        end
endtask

task automatic timeout_fail(input string what);
        $display("Timed out while %s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
endtask

`endif

//--- bench/tb_fifo_async.sv
`timescale 1ns/1ps

`include "fifo_cfg.svh"

module tb_fifo_async import fifo_pkg::*; ();

        logic           wr_clk;
        logic           wr_rst_n;
        logic           wr_en;
        fifo_data_t     wr_data;
        logic           rd_clk;
        logic           rd_rst_n;
        logic           rd_en;
        fifo_data_t     rd_data;
        fifo_wr_flags_t wr_flags;
        fifo_rd_flags_t rd_flags;

        int  pops_done;
        logic traffic_done;

`include "fifo_tb_util.svh"

        fifo_async fifo_async_i (
                .wr_clk   (wr_clk),
                .wr_rst_n (wr_rst_n),
                .wr_en    (wr_en),
                .wr_data  (wr_data),
                .rd_clk   (rd_clk),
                .rd_rst_n (rd_rst_n),
                .rd_en    (rd_en),
                .rd_data  (rd_data),
                .wr_flags (wr_flags),
                .rd_flags (rd_flags)
        );

        // Two free-running clocks, 40 ns, write side 13 ns late
        initial begin
                rd_clk = 1'b0;
                forever #20 rd_clk = ~rd_clk;
        end

        initial begin
                wr_clk = 1'b0;
                #13;
                forever #20 wr_clk = ~wr_clk;
        end

        // --------------------------------------------------
        // Per-domain cycles
        // --------------------------------------------------

        // Flags seen 2 ns after the edge hold for the coming edge
        task automatic write_cycle(input logic en, input fifo_data_t data);
                @(posedge wr_clk);
                #2;
                wr_en   = en;
                wr_data = data;
                if (en && !wr_flags.full) begin
                        model_q.push_back(data);
                end
        endtask

        // Head compare happens on every accepted pop
        task automatic read_cycle(input logic en);
                @(posedge rd_clk);
                #2;
                rd_en = en;
                if (en && !rd_flags.empty) begin
                        check_value("rd_data", model_q[0], rd_data);
                        void'(model_q.pop_front());
                        pops_done++;
                end
        endtask

        task automatic fill_to(input int n);
                int guard;
                guard = 0;
                while (model_q.size() < n) begin
                        write_cycle(1'b1, fifo_data_t'(rand_bits(8)));
                        guard++;
                        if (guard > 200) timeout_fail("filling the FIFO");
                end
                write_cycle(1'b0, '0);
        endtask

        task automatic drain_to(input int n);
                int guard;
                guard = 0;
                while (model_q.size() > n) begin
                        read_cycle(1'b1);
                        guard++;
                        if (guard > 200) timeout_fail("draining the FIFO");
                end
                read_cycle(1'b0);
        endtask

        // Eight edges in each domain, then compare every flag
        task automatic settle_and_check();
                fifo_wr_flags_t ew;
                fifo_rd_flags_t er;
                for (int i = 0; i < 8; i++) @(posedge rd_clk);
                for (int i = 0; i < 8; i++) @(posedge wr_clk);
                #2;
                ew = expect_wr_flags(model_q.size());
                er = expect_rd_flags(model_q.size());
                check_value("wr_flags.full", ew.full, wr_flags.full);
                check_value("wr_flags.almost_full", ew.almost_full, wr_flags.almost_full);
                check_value("rd_flags.empty", er.empty, rd_flags.empty);
                check_value("rd_flags.almost_empty", er.almost_empty, rd_flags.almost_empty);
                check_value("rd_flags.count", er.count, rd_flags.count);
        endtask

        // --------------------------------------------------
        // Main sequence
        // --------------------------------------------------

        initial begin
                fifo_data_t held;
                int         guard;
                int         wr_guard;
                wr_rst_n     = 1'b0;
                rd_rst_n     = 1'b0;
                wr_en        = 1'b0;
                wr_data      = '0;
                rd_en        = 1'b0;
                pops_done    = 0;
                traffic_done = 1'b0;
                repeat (5) @(posedge rd_clk);
                #2;
                wr_rst_n = 1'b1;
                rd_rst_n = 1'b1;

                // Reset state
                check_value("rd_flags.empty", 1, rd_flags.empty);
                check_value("rd_flags.count", 0, rd_flags.count);
                check_value("wr_flags.full", 0, wr_flags.full);
                settle_and_check();

                // Fill levels around both thresholds
                fill_to(1);
                settle_and_check();
                fill_to(2);
                settle_and_check();
                fill_to(3);
                settle_and_check();
                fill_to(13);
                settle_and_check();
                fill_to(14);
                settle_and_check();
                fill_to(15);
                settle_and_check();
                fill_to(16);
                settle_and_check();

                // Write into a full FIFO is dropped
                write_cycle(1'b1, 8'ha5);
                write_cycle(1'b0, '0);
                check_value("model size", 16, model_q.size());
                settle_and_check();
                drain_to(2);
                settle_and_check();
                drain_to(0);
                settle_and_check();

                // Pop while empty
                // Storage now holds distinct words, so a moved pointer shows up
                held = rd_data;
                for (int i = 0; i < 4; i++) read_cycle(1'b1);
                read_cycle(1'b0);
                check_value("model size", 0, model_q.size());
                check_value("rd_data", held, rd_data);
                check_value("rd_flags.empty", 1, rd_flags.empty);
                settle_and_check();

                // Random traffic until 2000 more pops
                pops_done = 0;
                fork
                        begin
                                wr_guard = 0;
                                while (!traffic_done) begin
                                        write_cycle(1'(rand_bits(1)), fifo_data_t'(rand_bits(8)));
                                        wr_guard++;
                                        if (wr_guard > 21000) begin
                                                timeout_fail("waiting for random reads");
                                        end
                                end
                                write_cycle(1'b0, '0);
                        end
                        begin
                                guard = 0;
                                while (pops_done < 2000) begin
                                        read_cycle(1'(rand_bits(1)));
                                        guard++;
                                        if (guard > 20000) timeout_fail("running random traffic");
                                end
                                read_cycle(1'b0);
                                traffic_done = 1'b1;
                        end
                join
                settle_and_check();

                $display("SIMULATION PASSED");
                $finish;
        end

endmodule

//--- files.f
+incdir+design
+incdir+bench
design/fifo_pkg.sv
design/fifo_ptr_domain.sv
design/fifo_ram.sv
design/fifo_control.sv
design/fifo_async.sv
bench/tb_fifo_async.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FIFO testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --Wno-fatal \
        -f files.f --top-module tb_fifo_async -o sim_fifo &&
./obj_dir/sim_fifo ||
{
        echo "Simulation run failed"
        exit 1
}
